//--- logic/display_scanner.sv
// seven-segment display scanner
// holds the last bcd word and lights one digit at a time
// with the decimal point on a fixed digit

`timescale 1ns/1ns

module display_scanner import freq_counter_pkg::*; #(
	// dwell per digit is 2**scan_log2 cycles
	parameter int scan_log2 = 12,
	// digit whose decimal point is lit
	parameter int dp_position = 2
) (
	input logic clock,
	input logic reset,
	input logic load,
	input bcd_t bcd,
	output segments_t segment,
	output anodes_t anode
);

	localparam int index_width = $clog2(digit_count);

	// word on show
	bcd_t held;
	// cycles spent on the current digit
	logic [scan_log2-1:0] dwell;
	// digit being lit
	logic [index_width-1:0] digit_index;
	digit_t digit;

	// hold the latest conversion
	always_ff @(posedge clock) begin
		if (reset) begin
			held <= '0;
		end else if (load) begin
			held <= bcd;
		end
	end

	// scan timing
	always_ff @(posedge clock) begin
		if (reset) begin
			dwell <= '0;
			digit_index <= '0;
		end else begin
			dwell <= dwell + 1'b1;
			// end of this dwell
			if (&dwell) begin
				if (digit_index == index_width'(digit_count - 1)) begin
					digit_index <= '0;
				end else begin
					digit_index <= digit_index + 1'b1;
				end
			end
		end
	end

	// current nibble to segments, one-hot anode
	always_comb begin
		digit = held[digit_index*4 +: 4];
		segment = digit_to_segments(digit);
		if (int'(digit_index) == dp_position) begin
			segment = segment | seg_dp;
		end
		anode = anodes_t'(1) << digit_index;
	end

endmodule

//--- logic/edge_accumulator.sv
// edge accumulator
// synchronizes the measured input, counts its rising edges while the window
// is open and captures the total when the window closes

`timescale 1ns/1ns

module edge_accumulator import freq_counter_pkg::*; (
	input logic clock,
	input logic reset,
	input logic signal_in,
	input logic window,
	output count_t count,
	output logic count_valid,
	output logic overflow
);

	// two flop synchronizer then the edge detect flop
	logic sync_meta;
	logic sync_stable;
	logic sync_last;
	logic rising;

	// window level from the previous cycle
	logic window_last;
	logic window_closing;

	// running total and its sticky saturation flag
	count_t total;
	logic total_overflow;

	always_comb begin
		rising = sync_stable & ~sync_last;
		// high on the first low cycle after the window was open
		window_closing = window_last & ~window;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			sync_meta <= 1'b0;
			sync_stable <= 1'b0;
			sync_last <= 1'b0;
			window_last <= 1'b0;
		end else begin
			sync_meta <= signal_in;
			sync_stable <= sync_meta;
			sync_last <= sync_stable;
			window_last <= window;
		end
	end

	// accumulate during the open window
	always_ff @(posedge clock) begin
		if (reset) begin
			total <= '0;
			total_overflow <= 1'b0;
		end else if (count_valid) begin
			// cycle after capture clears the running total
			total <= '0;
			total_overflow <= 1'b0;
		end else if (rising && window) begin
			if (total == '1) begin
				// hold at max
				total_overflow <= 1'b1;
			end else begin
				total <= total + 1'b1;
			end
		end
	end

	// capture at the closing edge, held until the next one
	always_ff @(posedge clock) begin
		if (reset) begin
			count_valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			count_valid <= window_closing;
			if (window_closing) begin
				overflow <= total_overflow;
			end
		end
	end

	// captured value itself
	always_ff @(posedge clock) begin
		if (window_closing) begin
			count <= total;
		end
	end

endmodule

//--- logic/freq_counter_pkg.sv
// frequency counter shared definitions
// count and digit widths, display word types and the seven-segment encoding

package freq_counter_pkg;

	// captured edge count width
	localparam int count_width = 24;
	// digits on the display
	localparam int digit_count = 8;

	typedef logic [count_width-1:0] count_t;
	typedef logic [3:0] digit_t;
	// digit 0 sits in the least significant nibble
	typedef logic [digit_count*4-1:0] bcd_t;
	// bit order g f e d c b a dp, active high
	typedef logic [7:0] segments_t;
	// one-hot digit select, active high
	typedef logic [digit_count-1:0] anodes_t;

	// decimal point bit of a segment pattern
	localparam segments_t seg_dp = 8'h01;

	// bcd nibble to segment pattern with dp clear
	function automatic segments_t digit_to_segments(input digit_t digit);
		case (digit)
			4'd0: digit_to_segments = 8'h7e;
			4'd1: digit_to_segments = 8'h0c;
			4'd2: digit_to_segments = 8'hb6;
			4'd3: digit_to_segments = 8'h9e;
			4'd4: digit_to_segments = 8'hcc;
			4'd5: digit_to_segments = 8'hda;
			4'd6: digit_to_segments = 8'hfa;
			4'd7: digit_to_segments = 8'h0e;
			4'd8: digit_to_segments = 8'hfe;
			4'd9: digit_to_segments = 8'hde;
			// not a decimal digit so nothing lit
			default: digit_to_segments = 8'h00;
		endcase
	endfunction

endpackage

//--- logic/freq_counter_top.sv
// frequency counter top level
// gate timer, edge accumulator, bcd converter and display scanner
// wired together with plain ports

`timescale 1ns/1ns

module freq_counter_top import freq_counter_pkg::*; #(
	// window length exponent, at least 6
	parameter int gate_log2 = 20,
	// display dwell exponent
	parameter int scan_log2 = 12,
	// lit decimal point digit
	parameter int dp_position = 2
) (
	input logic clock,
	input logic reset,
	input logic signal_in,
	output logic window,
	output logic count_valid,
	output logic overflow,
	output logic bcd_valid,
	output count_t count,
	output bcd_t bcd,
	output segments_t segment,
	output anodes_t anode
);

	// measurement window
	gate_timer #(
		.gate_log2(gate_log2)
	) gate_timer_inst (
		.clock(clock),
		.reset(reset),
		.window(window)
	);

	// edge count per window
	edge_accumulator edge_accumulator_inst (
		.clock(clock),
		.reset(reset),
		.signal_in(signal_in),
		.window(window),
		.count(count),
		.count_valid(count_valid),
		.overflow(overflow)
	);

	// captured count to decimal
	hex_to_bcd hex_to_bcd_inst (
		.clock(clock),
		.reset(reset),
		.start(count_valid),
		.value(count),
		.bcd(bcd),
		.done(bcd_valid)
	);

	// multiplexed display
	display_scanner #(
		.scan_log2(scan_log2),
		.dp_position(dp_position)
	) display_scanner_inst (
		.clock(clock),
		.reset(reset),
		.load(bcd_valid),
		.bcd(bcd),
		.segment(segment),
		.anode(anode)
	);

endmodule

//--- logic/gate_timer.sv
// gate timer
// free-running counter whose top bit opens and closes the measurement window
// open and closed intervals are each 2**gate_log2 clock cycles

`timescale 1ns/1ns

module gate_timer #(
	// window length exponent
	// must be at least 6 so the bcd converter finishes between captures
	parameter int gate_log2 = 20
) (
	input logic clock,
	input logic reset,
	output logic window
);

	// one extra bit above the window length
	logic [gate_log2:0] gate_count;
	logic [gate_log2:0] gate_next;

	// next count value
	always_comb begin
		gate_next = gate_count + 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			gate_count <= '0;
			window <= 1'b0;
		end else begin
			gate_count <= gate_next;
			// top bit of the next value
			// so the first open interval starts 2**gate_log2 cycles after reset
			window <= gate_next[gate_log2];
		end
	end

endmodule

//--- logic/hex_to_bcd.sv
// binary to bcd converter
// iterative double dabble, one adjust and shift step per clock
// done pulses 25 cycles after start with eight bcd digits

`timescale 1ns/1ns

module hex_to_bcd import freq_counter_pkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	input count_t value,
	output bcd_t bcd,
	output logic done
);

	localparam int bcd_width = digit_count * 4;
	localparam int shift_width = bcd_width + count_width;
	localparam int step_width = $clog2(count_width + 1);

	// bcd digits above, binary value below
	logic [shift_width-1:0] shift_reg;
	logic [shift_width-1:0] adjusted;
	logic [shift_width-1:0] shifted;

	// steps still to go
	logic [step_width-1:0] steps_left;
	logic busy;

	// add three to each digit above four, then shift left one bit
	always_comb begin
		adjusted = shift_reg;
		for (int i = 0; i < digit_count; i++) begin
			if (shift_reg[count_width + i*4 +: 4] > 4'd4) begin
				adjusted[count_width + i*4 +: 4] = shift_reg[count_width + i*4 +: 4] + 4'd3;
			end
		end
		shifted = {adjusted[shift_width-2:0], 1'b0};
	end

	// step control
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			steps_left <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				steps_left <= step_width'(count_width);
			end else if (busy) begin
				steps_left <= steps_left - 1'b1;
				// last step presents the digits
				if (steps_left == 1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (start) begin
			shift_reg <= {{bcd_width{1'b0}}, value};
		end else if (busy) begin
			shift_reg <= shifted;
		end
	end

	// result word, loaded together with done
	always_ff @(posedge clock) begin
		if (busy && steps_left == 1) begin
			bcd <= shifted[shift_width-1:count_width];
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the frequency counter simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module freq_counter_tb -o freq_counter_sim

status=0
./obj_dir/freq_counter_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then
	echo "simulation failed (exit status $status)"
	exit 1
fi

echo "simulation passed"
exit 0

//--- sim.f
logic/freq_counter_pkg.sv
logic/gate_timer.sv
logic/edge_accumulator.sv
logic/hex_to_bcd.sv
logic/display_scanner.sv
logic/freq_counter_top.sv
verification/freq_counter_props.sv
verification/freq_counter_tb.sv

//--- verification/freq_counter_props.sv
// frequency counter assertions
// capture timing, converter latency, one-hot scan and reset state

`timescale 1ns/1ns

module freq_counter_props import freq_counter_pkg::*; (
	input logic clock,
	input logic reset,
	input logic window,
	input logic count_valid,
	input logic bcd_valid,
	input anodes_t anode
);

	// reset level at the previous edge
	logic reset_held;

	always @(posedge clock) begin
		reset_held <= reset;
	end

	// capture one cycle after the first low window cycle
	assert property (@(posedge clock) disable iff (reset)
		count_valid |-> !$past(window) && $past(window, 2))
		else $error("count_valid without a preceding falling edge of window");

	// converter takes a fixed 25 cycles
	assert property (@(posedge clock) disable iff (reset)
		$rose(count_valid) |-> ##25 bcd_valid)
		else $error("bcd_valid missing 25 cycles after count_valid");

	assert property (@(posedge clock) disable iff (reset)
		$rose(bcd_valid) |-> $past(count_valid, 25))
		else $error("bcd_valid without count_valid 25 cycles earlier");

	// exactly one digit lit, either held or moved on to the next digit
	assert property (@(posedge clock) disable iff (reset)
		$onehot(anode) && (anode == $past(anode)
			|| anode == (($past(anode) << 1) | ($past(anode) >> (digit_count - 1)))))
		else $error("anode is not one-hot or skipped a digit");

	// both pulses held low once reset has been applied
	assert property (@(posedge clock)
		reset && reset_held |-> !count_valid && !bcd_valid)
		else $error("valid pulse during reset");

endmodule

bind freq_counter_top freq_counter_props freq_counter_props_inst (
	.clock(clock),
	.reset(reset),
	.window(window),
	.count_valid(count_valid),
	.bcd_valid(bcd_valid),
	.anode(anode)
);

//--- verification/freq_counter_tb.sv
// frequency counter testbench
// drives pulse bursts into measurement windows and checks the captured count,
// its bcd form and the scanned display digits

`timescale 1ns/1ns

module freq_counter_tb import freq_counter_pkg::*; ();

	localparam int gate_log2 = 8;
	localparam int scan_log2 = 3;
	localparam int dp_position = 2;
	localparam int clock_period = 100;
	localparam int window_length = 1 << gate_log2;
	// cycles from count_valid to bcd_valid
	localparam int bcd_latency = 25;
	localparam int row_count = 8;
	// rows plus three window periods
	localparam int timeout_ns = (row_count + 3) * 2 * window_length * clock_period;

	logic clock;
	logic reset;
	logic signal_in;
	logic window;
	logic count_valid;
	logic overflow;
	logic bcd_valid;
	count_t count;
	bcd_t bcd;
	segments_t segment;
	anodes_t anode;

	// stimulus table: name, pulses in the window, pulse spacing,
	// pulses in the preceding closed interval, random pulse count
	string row_name [row_count] = '{"zero_pulses", "nine", "ten", "ninety_nine",
		"hundred", "closed_interval", "random_wide", "random_dense"};
	int row_pulses [row_count] = '{0, 9, 10, 99, 100, 5, 0, 0};
	int row_spacing [row_count] = '{4, 8, 3, 2, 2, 6, 5, 2};
	int row_closed [row_count] = '{0, 0, 0, 0, 0, 12, 0, 0};
	bit row_random [row_count] = '{0, 0, 0, 0, 0, 0, 1, 1};

	freq_counter_top #(
		.gate_log2(gate_log2),
		.scan_log2(scan_log2),
		.dp_position(dp_position)
	) freq_counter_top_inst (
		.clock(clock),
		.reset(reset),
		.signal_in(signal_in),
		.window(window),
		.count_valid(count_valid),
		.overflow(overflow),
		.bcd_valid(bcd_valid),
		.count(count),
		.bcd(bcd),
		.segment(segment),
		.anode(anode)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_count(input string name, input count_t expected, input count_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected count %0d, actual %0d", name, expected, actual);
			fail_run("count mismatch");
		end
	endtask

	task automatic check_bcd(input string name, input bcd_t expected, input bcd_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected bcd %h, actual %h", name, expected, actual);
			fail_run("bcd mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			fail_run("flag mismatch");
		end
	endtask

	task automatic check_segments(input string name, input segments_t expected,
		input segments_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected segments %h, actual %h", name, expected, actual);
			fail_run("segment mismatch");
		end
	endtask

	task automatic check_cycles(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("ERROR %s: expected %0d cycles, actual %0d", name, expected, actual);
			fail_run("cycle count mismatch");
		end
	endtask

	// decimal digits by repeated division, digit 0 lowest
	function automatic bcd_t decimal_digits(input int value);
		bcd_t result;
		int rest;
		result = '0;
		rest = value;
		for (int i = 0; i < digit_count; i++) begin
			result[i*4 +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return result;
	endfunction

	// one cycle high, then low for the rest of the spacing
	task automatic drive_pulse(input int spacing);
		@(posedge clock);
		signal_in <= 1'b1;
		@(posedge clock);
		signal_in <= 1'b0;
		repeat (spacing - 2) @(posedge clock);
	endtask

	task automatic wait_window_rise();
		@(negedge clock);
		while (window) @(negedge clock);
		while (!window) @(negedge clock);
	endtask

	// walk the scan through all eight digits
	task automatic check_display(input string name, input bcd_t expected);
		segments_t want;
		anodes_t select;
		// scanner loads on the edge after bcd_valid
		@(negedge clock);
		for (int i = 0; i < digit_count; i++) begin
			select = anodes_t'(1) << i;
			while (anode !== select) @(negedge clock);
			// segment lines a to g, dp compared on its own
			want = digit_to_segments(expected[i*4 +: 4]);
			check_segments($sformatf("%s digit %0d", name, i), want, segment & ~seg_dp);
			check_flag($sformatf("%s dp %0d", name, i), logic'(i == dp_position), segment[0]);
		end
	endtask

	task automatic run_row(input int r);
		string name;
		int pulses;
		int spacing;
		int latency;
		bcd_t expected_bcd;
		name = row_name[r];
		spacing = row_spacing[r];
		pulses = row_pulses[r];
		if (row_random[r]) begin
			pulses = int'($urandom % 32'((window_length - 12) / spacing + 1));
		end
		if (pulses * spacing + 12 > window_length) begin
			fail_run({"stimulus row ", name, " does not fit inside the window"});
		end
		// pulses that must not be counted
		if (row_closed[r] > 0) begin
			repeat (row_closed[r]) drive_pulse(spacing);
			@(negedge clock);
			check_flag({name, " closed interval"}, 1'b0, window);
		end
		wait_window_rise();
		// keep clear of the opening edge
		repeat (4) @(posedge clock);
		repeat (pulses) drive_pulse(spacing);
		@(negedge clock);
		while (!count_valid) @(negedge clock);
		check_count(name, count_t'(pulses), count);
		check_flag({name, " overflow"}, 1'b0, overflow);
		latency = 1;
		@(negedge clock);
		while (!bcd_valid) begin
			latency++;
			@(negedge clock);
		end
		check_cycles({name, " bcd latency"}, bcd_latency, latency);
		expected_bcd = decimal_digits(pulses);
		check_bcd(name, expected_bcd, bcd);
		check_display(name, expected_bcd);
	endtask

	initial begin
		void'($urandom(29003));
		reset = 1'b1;
		signal_in = 1'b0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		for (int r = 0; r < row_count; r++) begin
			run_row(r);
		end
		$display("Simulation PASSED");
		$finish;
	end

	// open and closed intervals at the window port
	initial begin : window_monitor
		logic last_level;
		int run_length;
		bit seen_change;
		seen_change = 1'b0;
		run_length = 0;
		@(negedge clock);
		while (reset) @(negedge clock);
		last_level = window;
		forever begin
			@(negedge clock);
			if (window !== last_level) begin
				if (seen_change) begin
					check_cycles("window_interval", window_length, run_length);
				end
				seen_change = 1'b1;
				run_length = 1;
				last_level = window;
			end else begin
				run_length++;
			end
		end
	end

	initial begin
		#(timeout_ns);
		fail_run("watchdog timeout: the test did not finish in the expected time");
	end

endmodule
